//--- hw/hl_pkg.sv
// Shared types and constants for the Hermes-Lite 2 control slice.
// Host command words follow the openhpsdr style: 6-bit address, 32-bit payload.
// AD9866 writes are 16-bit frames, MSB first: write bit 0, one 0 bit,
// 6 address bits, 8 data bits. Readback is not supported.
package hl_pkg;

  typedef logic [5:0]  host_addr_t;
  typedef logic [31:0] host_data_t;

  typedef struct packed {
    host_addr_t addr;
    host_data_t data;
  } host_cmd_t;

  typedef logic [5:0] ad9866_addr_t;
  typedef logic [7:0] ad9866_data_t;

  typedef struct packed {
    ad9866_addr_t addr;
    ad9866_data_t data;
  } ad9866_wr_t;

  // 0 keeps the fan off, N gives N high cycles out of every 256
  typedef logic [7:0] fan_duty_t;

  typedef struct packed {
    logic       req;
    ad9866_wr_t wr;
  } spi_req_t;

  localparam host_addr_t CMD_AD9866_WR = 6'h3B;
  localparam host_addr_t CMD_FAN_DUTY  = 6'h3C;

  localparam int SPI_FRAME_LEN = 16;

  // Clock, filter and gain defaults written once after reset
  localparam int AD9866_INIT_LEN = 4;
  localparam ad9866_wr_t AD9866_INIT_TABLE [AD9866_INIT_LEN] = '{
    '{addr: 6'h04, data: 8'h36},
    '{addr: 6'h08, data: 8'hff},
    '{addr: 6'h0e, data: 8'h81},
    '{addr: 6'h10, data: 8'h01}
  };

endpackage

//--- hw/host_cmd_decode.sv
// Host command decoder.
// Only CMD_AD9866_WR and CMD_FAN_DUTY are acted on, other addresses are dropped.
// One AD9866 write can be pending; a newer command replaces an ungranted one.
`timescale 1ns/1ns

module host_cmd_decode (
  input  logic              clk_ad9866,
  input  logic              rst_n,
  input  logic              cmd_valid,
  input  hl_pkg::host_cmd_t cmd,
  input  logic              grant,
  output hl_pkg::spi_req_t  req,
  output hl_pkg::fan_duty_t fan_duty
);

  import hl_pkg::*;

  logic       is_ad9866_wr;
  logic       is_fan_duty;
  logic       loaded_q;
  logic       pend_q;
  ad9866_wr_t pend_wr_q;

  assign is_ad9866_wr = cmd_valid && (cmd.addr == CMD_AD9866_WR);
  assign is_fan_duty  = cmd_valid && (cmd.addr == CMD_FAN_DUTY);

  // The arbiter registers its grant, so a grant seen now refers to the
  // request as it stood one cycle earlier. If a new write was loaded on
  // the last edge, the grant belongs to the old one and the new one stays.
  always_ff @(posedge clk_ad9866) begin
    if (!rst_n) begin
      pend_q   <= 1'b0;
      loaded_q <= 1'b0;
    end else begin
      loaded_q <= is_ad9866_wr;
      if (is_ad9866_wr) begin
        pend_q <= 1'b1;
      end else if (grant && !loaded_q) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_ad9866) begin
    if (is_ad9866_wr) begin
      pend_wr_q.addr <= cmd.data[13:8];
      pend_wr_q.data <= cmd.data[7:0];
    end
  end

  always_ff @(posedge clk_ad9866) begin
    if (!rst_n) begin
      fan_duty <= '0;
    end else if (is_fan_duty) begin
      fan_duty <= cmd.data[7:0];
    end
  end

  assign req.req = pend_q;
  assign req.wr  = pend_wr_q;

endmodule

//--- hw/ad9866_init.sv
// AD9866 startup sequencer.
// Requests every entry of AD9866_INIT_TABLE in order, one per grant, then
// waits for the last frame to finish before raising init_done.
// init_done stays high until the next reset.
`timescale 1ns/1ns

module ad9866_init (
  input  logic             clk_ad9866,
  input  logic             rst_n,
  input  logic             grant,
  input  logic             spi_busy,
  output hl_pkg::spi_req_t req,
  output logic             init_done
);

  import hl_pkg::*;

  localparam int IDX_W = $clog2(AD9866_INIT_LEN);

  typedef enum logic [1:0] {
    ST_RUN,
    ST_DRAIN,
    ST_DONE
  } state_t;

  state_t           state;
  logic [IDX_W-1:0] idx;
  logic             busy_q;
  logic             last_entry;
  logic             busy_fall;

  assign last_entry = (idx == IDX_W'(AD9866_INIT_LEN - 1));
  assign busy_fall  = busy_q && !spi_busy;

  always_ff @(posedge clk_ad9866) begin
    if (!rst_n) begin
      state  <= ST_RUN;
      idx    <= '0;
      busy_q <= 1'b0;
    end else begin
      busy_q <= spi_busy;
      case (state)
        ST_RUN: begin
          if (grant) begin
            if (last_entry) begin
              state <= ST_DRAIN;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        // Last frame granted, hold off until the engine goes idle again
        ST_DRAIN: begin
          if (busy_fall) begin
            state <= ST_DONE;
          end
        end
        default: state <= ST_DONE;
      endcase
    end
  end

  assign req.req   = (state == ST_RUN);
  assign req.wr    = AD9866_INIT_TABLE[idx];
  assign init_done = (state == ST_DONE);

endmodule

//--- hw/spi_arbiter.sv
// Fixed-priority arbiter for the AD9866 serial engine.
// The startup sequencer wins over the host. A grant is a one-cycle pulse,
// issued only while the engine is idle and no start is already on its way.
`timescale 1ns/1ns

module spi_arbiter (
  input  logic               clk_ad9866,
  input  logic               rst_n,
  input  hl_pkg::spi_req_t   req_init,
  input  hl_pkg::spi_req_t   req_host,
  input  logic               spi_busy,
  output logic               grant_init,
  output logic               grant_host,
  output logic               spi_start,
  output hl_pkg::ad9866_wr_t spi_wr
);

  import hl_pkg::*;

  logic idle;
  logic pick_init;
  logic pick_host;

  // spi_busy rises only the cycle after spi_start, so the start itself
  // has to block a second grant
  assign idle      = !spi_busy && !spi_start;
  assign pick_init = idle && req_init.req;
  assign pick_host = idle && !req_init.req && req_host.req;

  always_ff @(posedge clk_ad9866) begin
    if (!rst_n) begin
      grant_init <= 1'b0;
      grant_host <= 1'b0;
    end else begin
      grant_init <= pick_init;
      grant_host <= pick_host;
    end
  end

  always_ff @(posedge clk_ad9866) begin
    if (pick_init) begin
      spi_wr <= req_init.wr;
    end else if (pick_host) begin
      spi_wr <= req_host.wr;
    end
  end

  assign spi_start = grant_init || grant_host;

endmodule

//--- hw/ad9866_spi.sv
// Write-only serial engine for the AD9866 three-wire port.
// One 16-bit frame per spi_start, MSB first. sdio changes while sclk is low,
// sclk is low then high for SCLK_DIV clocks each per bit.
// A frame lasts 32*SCLK_DIV+2 clocks from spi_start to spi_busy low.
// spi_start is ignored while a frame is in flight.
`timescale 1ns/1ns

module ad9866_spi #(
  parameter int SCLK_DIV = 4
) (
  input  logic               clk_ad9866,
  input  logic               rst_n,
  input  logic               spi_start,
  input  hl_pkg::ad9866_wr_t spi_wr,
  output logic               spi_busy,
  output logic               ad9866_sclk,
  output logic               ad9866_sdio,
  output logic               ad9866_sen_n
);

  import hl_pkg::*;

  localparam int DIV_W = $clog2(SCLK_DIV + 1);
  localparam int BIT_W = $clog2(SPI_FRAME_LEN);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_END
  } state_t;

  state_t                   state;
  logic [DIV_W-1:0]         div_cnt;
  logic [BIT_W-1:0]         bit_cnt;
  logic [SPI_FRAME_LEN-1:0] shreg;
  logic [SPI_FRAME_LEN-1:0] frame;
  logic                     phase_end;

  // Write bit and the unused bit are both zero
  assign frame     = {2'b00, spi_wr.addr, spi_wr.data};
  assign phase_end = (div_cnt == DIV_W'(SCLK_DIV - 1));

  always_ff @(posedge clk_ad9866) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      div_cnt      <= '0;
      bit_cnt      <= '0;
      spi_busy     <= 1'b0;
      ad9866_sclk  <= 1'b0;
      ad9866_sdio  <= 1'b0;
      ad9866_sen_n <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (spi_start) begin
            state        <= ST_SHIFT;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            spi_busy     <= 1'b1;
            ad9866_sen_n <= 1'b0;
            ad9866_sclk  <= 1'b0;
            ad9866_sdio  <= frame[SPI_FRAME_LEN-1];
          end
        end
        ST_SHIFT: begin
          if (phase_end) begin
            div_cnt <= '0;
            if (!ad9866_sclk) begin
              ad9866_sclk <= 1'b1;
            end else begin
              ad9866_sclk <= 1'b0;
              if (bit_cnt == BIT_W'(SPI_FRAME_LEN - 1)) begin
                state        <= ST_END;
                ad9866_sen_n <= 1'b1;
                ad9866_sdio  <= 1'b0;
              end else begin
                bit_cnt     <= bit_cnt + 1'b1;
                ad9866_sdio <= shreg[SPI_FRAME_LEN-2];
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        // sen_n is already high, release busy one clock later
        default: begin
          state    <= ST_IDLE;
          spi_busy <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_ad9866) begin
    if (state == ST_IDLE && spi_start) begin
      shreg <= frame;
    end else if (state == ST_SHIFT && phase_end && ad9866_sclk) begin
      shreg <= shreg << 1;
    end
  end

endmodule

//--- hw/fan_pwm.sv
// Fan PWM with a free-running 8-bit period.
// Output is high while the counter is below fan_duty, so a duty of N
// gives N high clocks per 256. The output is registered.
`timescale 1ns/1ns

module fan_pwm (
  input  logic              clk_ad9866,
  input  logic              rst_n,
  input  hl_pkg::fan_duty_t fan_duty,
  output logic              fan_pwm
);

  import hl_pkg::*;

  fan_duty_t pwm_cnt;

  always_ff @(posedge clk_ad9866) begin
    if (!rst_n) begin
      pwm_cnt <= '0;
      fan_pwm <= 1'b0;
    end else begin
      // Wraps modulo 256
      pwm_cnt <= pwm_cnt + 1'b1;
      fan_pwm <= (pwm_cnt < fan_duty);
    end
  end

endmodule

//--- hw/hermeslite.sv
// Hermes-Lite 2 control slice: host command decode, AD9866 serial setup
// and fan PWM. No Ethernet, DSP, clock chip, UART or ATU logic here.
// The AD9866 port is write only. SCLK_DIV sets the serial clock half period
// in clk_ad9866 cycles.
`timescale 1ns/1ns

module hermeslite #(
  parameter int SCLK_DIV = 4
) (
  input  logic              clk_ad9866,
  input  logic              rst_n,
  // Host command strobe
  input  logic              cmd_valid,
  input  hl_pkg::host_cmd_t cmd,
  // AD9866 serial port
  output logic              ad9866_sclk,
  output logic              ad9866_sdio,
  output logic              ad9866_sen_n,
  // Board IO
  output logic              fan_pwm,
  output logic              io_led_run
);

  import hl_pkg::*;

  spi_req_t   req_init;
  spi_req_t   req_host;
  logic       grant_init;
  logic       grant_host;
  logic       spi_start;
  logic       spi_busy;
  ad9866_wr_t spi_wr;
  fan_duty_t  fan_duty;
  logic       init_done;

  host_cmd_decode host_cmd_decode_i (
    .clk_ad9866(clk_ad9866),
    .rst_n     (rst_n     ),
    .cmd_valid (cmd_valid ),
    .cmd       (cmd       ),
    .grant     (grant_host),
    .req       (req_host  ),
    .fan_duty  (fan_duty  )
  );

  ad9866_init ad9866_init_i (
    .clk_ad9866(clk_ad9866),
    .rst_n     (rst_n     ),
    .grant     (grant_init),
    .spi_busy  (spi_busy  ),
    .req       (req_init  ),
    .init_done (init_done )
  );

  spi_arbiter spi_arbiter_i (
    .clk_ad9866(clk_ad9866),
    .rst_n     (rst_n     ),
    .req_init  (req_init  ),
    .req_host  (req_host  ),
    .spi_busy  (spi_busy  ),
    .grant_init(grant_init),
    .grant_host(grant_host),
    .spi_start (spi_start ),
    .spi_wr    (spi_wr    )
  );

  ad9866_spi #(
    .SCLK_DIV(SCLK_DIV)
  ) ad9866_spi_i (
    .clk_ad9866  (clk_ad9866  ),
    .rst_n       (rst_n       ),
    .spi_start   (spi_start   ),
    .spi_wr      (spi_wr      ),
    .spi_busy    (spi_busy    ),
    .ad9866_sclk (ad9866_sclk ),
    .ad9866_sdio (ad9866_sdio ),
    .ad9866_sen_n(ad9866_sen_n)
  );

  fan_pwm fan_pwm_i (
    .clk_ad9866(clk_ad9866),
    .rst_n     (rst_n     ),
    .fan_duty  (fan_duty  ),
    .fan_pwm   (fan_pwm   )
  );

  // Run LED lights once the startup table is in the AD9866
  assign io_led_run = init_done;

endmodule

//--- verification/hermeslite_sva.sv
// Assertions on the AD9866 serial pins and the arbiter grants.
// Bound into hermeslite, so the grants are read from its internal wires.
`timescale 1ns/1ns

module hermeslite_sva (
  input logic clk_ad9866,
  input logic rst_n,
  input logic ad9866_sclk,
  input logic ad9866_sdio,
  input logic ad9866_sen_n,
  input logic grant_init,
  input logic grant_host
);

  // The first reset edge is skipped, the pins are unknown before it
  sen_n_high_in_reset: assert property (@(posedge clk_ad9866)
    (!rst_n && $past(!rst_n)) |-> ad9866_sen_n)
    else $error("sen_n was low during reset");

  sdio_stable_sclk_high: assert property (@(posedge clk_ad9866) disable iff (!rst_n)
    (ad9866_sclk && !ad9866_sen_n) |-> $stable(ad9866_sdio))
    else $error("sdio changed while sclk was high");

  sclk_low_when_idle: assert property (@(posedge clk_ad9866) disable iff (!rst_n)
    ad9866_sen_n |-> !ad9866_sclk)
    else $error("sclk was high while sen_n was high");

  grants_exclusive: assert property (@(posedge clk_ad9866) disable iff (!rst_n)
    !(grant_init && grant_host))
    else $error("both requesters were granted in the same cycle");

endmodule

bind hermeslite hermeslite_sva hermeslite_sva_i (
  .clk_ad9866  (clk_ad9866  ),
  .rst_n       (rst_n       ),
  .ad9866_sclk (ad9866_sclk ),
  .ad9866_sdio (ad9866_sdio ),
  .ad9866_sen_n(ad9866_sen_n),
  .grant_init  (grant_init  ),
  .grant_host  (grant_host  )
);

//--- verification/tb_hermeslite.sv
// Testbench for the Hermes-Lite 2 control slice, run with SCLK_DIV = 2.
// Frames are captured from the AD9866 pins and checked in order against the
// expected writes, so an extra or missing frame is caught as well.
// Random values come from a 16-bit Galois LFSR seeded with 11.
`timescale 1ns/1ns

module tb_hermeslite;

  import hl_pkg::*;

  localparam int SCLK_DIV    = 2;
  localparam int FRAME_CYC   = 32 * SCLK_DIV + 2;
  localparam int N_RAND_WR   = 20;
  localparam int N_FAN       = 6;
  localparam int N_FRAMES    = AD9866_INIT_LEN + 1 + N_RAND_WR + 2;
  localparam int TIMEOUT_CYC = N_FRAMES * (FRAME_CYC + 8) + 3 * FRAME_CYC
                               + N_FAN * (256 + 4) + 500;

  logic        clk_ad9866;
  logic        rst_n;
  logic        cmd_valid;
  host_cmd_t   cmd;
  logic        ad9866_sclk;
  logic        ad9866_sdio;
  logic        ad9866_sen_n;
  logic        fan_pwm;
  logic        io_led_run;

  logic [15:0] lfsr_state;
  logic [15:0] cap_q[$];
  ad9866_wr_t  exp_q[$];
  string       exp_name_q[$];
  int          checked_cnt = 0;
  logic        led_on = 1'b0;
  logic        sclk_q;
  logic        sen_q;
  logic [15:0] cap_reg;
  int          cap_bits;

  hermeslite #(
    .SCLK_DIV(SCLK_DIV)
  ) dut_i (
    .clk_ad9866  (clk_ad9866  ),
    .rst_n       (rst_n       ),
    .cmd_valid   (cmd_valid   ),
    .cmd         (cmd         ),
    .ad9866_sclk (ad9866_sclk ),
    .ad9866_sdio (ad9866_sdio ),
    .ad9866_sen_n(ad9866_sen_n),
    .fan_pwm     (fan_pwm     ),
    .io_led_run  (io_led_run  )
  );

  initial begin
    clk_ad9866 = 1'b0;
    forever #10 clk_ad9866 = ~clk_ad9866;
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Frame rule: write bit 0, a 0 bit, 6 address bits, 8 data bits, MSB first
  function automatic logic [15:0] expected_frame(ad9866_wr_t wr);
    return {1'b0, 1'b0, wr.addr, wr.data};
  endfunction

  task automatic check_frame(string name, ad9866_wr_t exp_wr, logic [15:0] got);
    logic [15:0] exp;
    exp = expected_frame(exp_wr);
    if (got !== exp) begin
      fail_run($sformatf("error %s: expected %h actual %h", name, exp, got));
    end
  endtask

  task automatic check_duty(string name, fan_duty_t exp, fan_duty_t got);
    if (got !== exp) begin
      fail_run($sformatf("error %s: expected %0d actual %0d", name, exp, got));
    end
  endtask

  task automatic check_bit(string name, logic exp, logic got);
    if (got !== exp) begin
      fail_run($sformatf("error %s: expected %b actual %b", name, exp, got));
    end
  endtask

  // One LFSR step per bit taken, the output bit is the one shifted out
  function automatic logic [31:0] draw_bits(int n);
    logic [31:0] v;
    logic        out;
    v = '0;
    for (int i = 0; i < n; i++) begin
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) begin
        lfsr_state = lfsr_state ^ 16'hB400;
      end
      v = {v[30:0], out};
    end
    return v;
  endfunction

  function automatic ad9866_wr_t random_wr();
    ad9866_wr_t wr;
    wr.addr = ad9866_addr_t'(draw_bits(6));
    wr.data = ad9866_data_t'(draw_bits(8));
    return wr;
  endfunction

  // Upper payload bits are random and must be ignored by the decoder
  function automatic host_data_t wr_payload(ad9866_wr_t wr);
    logic [17:0] junk;
    junk = 18'(draw_bits(18));
    return {junk, wr.addr, wr.data};
  endfunction

  task automatic send_cmd(host_addr_t addr, host_data_t data);
    @(posedge clk_ad9866);
    cmd_valid <= 1'b1;
    cmd.addr  <= addr;
    cmd.data  <= data;
  endtask

  task automatic end_cmd();
    @(posedge clk_ad9866);
    cmd_valid <= 1'b0;
  endtask

  task automatic expect_wr(string name, ad9866_wr_t wr);
    exp_q.push_back(wr);
    exp_name_q.push_back(name);
  endtask

  task automatic wait_checked(int n);
    while (checked_cnt < n) begin
      @(posedge clk_ad9866);
    end
  endtask

  // Frame capture: sdio is taken on each sclk rise while sen_n is low
  always @(posedge clk_ad9866) begin
    if (!rst_n) begin
      sclk_q   <= 1'b0;
      sen_q    <= 1'b1;
      cap_reg  <= '0;
      cap_bits <= 0;
    end else begin
      sclk_q <= ad9866_sclk;
      sen_q  <= ad9866_sen_n;
      if (!ad9866_sen_n && sen_q) begin
        cap_reg  <= '0;
        cap_bits <= 0;
      end else if (!ad9866_sen_n && ad9866_sclk && !sclk_q) begin
        cap_reg  <= {cap_reg[14:0], ad9866_sdio};
        cap_bits <= cap_bits + 1;
      end
      if (ad9866_sen_n && !sen_q) begin
        if (cap_bits != 16) begin
          fail_run($sformatf("a frame had %0d clock pulses instead of 16", cap_bits));
        end else begin
          cap_q.push_back(cap_reg);
        end
      end
    end
  end

  // Compare process, also watches the run LED
  always @(negedge clk_ad9866) begin
    logic [15:0] got;
    while (cap_q.size() > 0) begin
      got = cap_q.pop_front();
      if (exp_q.size() == 0) begin
        fail_run($sformatf("frame %h was sent that no command asked for", got));
      end else begin
        check_frame(exp_name_q.pop_front(), exp_q.pop_front(), got);
        checked_cnt = checked_cnt + 1;
      end
    end
    if (rst_n) begin
      if (checked_cnt < AD9866_INIT_LEN) begin
        check_bit("led_run_during_init", 1'b0, io_led_run);
      end
      if (led_on) begin
        check_bit("led_run_stays_on", 1'b1, io_led_run);
      end
      led_on = led_on || io_led_run;
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk_ad9866);
    fail_run($sformatf("timeout, the run did not end within %0d clock cycles",
                       TIMEOUT_CYC));
  end

  initial begin : main_flow
    ad9866_wr_t wr;
    ad9866_wr_t dropped;
    fan_duty_t  duty_list [N_FAN];
    int         high_cnt;

    rst_n      <= 1'b0;
    cmd_valid  <= 1'b0;
    cmd        <= '0;
    lfsr_state = 16'd11;
    for (int i = 0; i < AD9866_INIT_LEN; i++) begin
      expect_wr($sformatf("init_table_%0d", i), AD9866_INIT_TABLE[i]);
    end
    repeat (4) @(posedge clk_ad9866);
    rst_n <= 1'b1;

    // Host write while the startup table is still going out
    repeat (10) @(posedge clk_ad9866);
    wr = random_wr();
    expect_wr("host_during_init", wr);
    send_cmd(CMD_AD9866_WR, wr_payload(wr));
    end_cmd();
    wait_checked(AD9866_INIT_LEN);
    repeat (3) @(posedge clk_ad9866);
    check_bit("led_run_after_init", 1'b1, io_led_run);
    wait_checked(AD9866_INIT_LEN + 1);

    for (int i = 0; i < N_RAND_WR; i++) begin
      wr = random_wr();
      expect_wr($sformatf("random_wr_%0d", i), wr);
      send_cmd(CMD_AD9866_WR, wr_payload(wr));
      end_cmd();
      wait_checked(AD9866_INIT_LEN + 2 + i);
    end

    // Two writes during a frame, only the newer one may go out
    wr = random_wr();
    expect_wr("in_flight", wr);
    send_cmd(CMD_AD9866_WR, wr_payload(wr));
    end_cmd();
    while (ad9866_sen_n) begin
      @(posedge clk_ad9866);
    end
    dropped = random_wr();
    wr = random_wr();
    expect_wr("newest_wins", wr);
    send_cmd(CMD_AD9866_WR, wr_payload(dropped));
    send_cmd(CMD_AD9866_WR, wr_payload(wr));
    end_cmd();
    wait_checked(N_FRAMES);

    send_cmd(6'h12, wr_payload(random_wr()));
    end_cmd();
    repeat (2 * FRAME_CYC) @(posedge clk_ad9866);

    check_bit("fan_off_after_reset", 1'b0, fan_pwm);
    duty_list[0] = 8'd0;
    duty_list[1] = 8'd255;
    for (int i = 2; i < N_FAN; i++) begin
      duty_list[i] = fan_duty_t'(draw_bits(8));
    end
    for (int i = 0; i < N_FAN; i++) begin
      send_cmd(CMD_FAN_DUTY, {24'(draw_bits(24)), duty_list[i]});
      end_cmd();
      @(posedge clk_ad9866);
      high_cnt = 0;
      repeat (256) begin
        @(posedge clk_ad9866);
        if (fan_pwm) begin
          high_cnt = high_cnt + 1;
        end
      end
      if (high_cnt > 255) begin
        fail_run("fan output stayed high for a whole 256-cycle window");
      end
      check_duty($sformatf("fan_duty_%0d", i), duty_list[i], fan_duty_t'(high_cnt));
    end

    if (exp_q.size() != 0 || cap_q.size() != 0) begin
      fail_run("some expected AD9866 frames were never sent");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

//--- files.f
hw/hl_pkg.sv
hw/host_cmd_decode.sv
hw/ad9866_init.sv
hw/spi_arbiter.sv
hw/ad9866_spi.sv
hw/fan_pwm.sv
hw/hermeslite.sv
verification/hermeslite_sva.sv
verification/tb_hermeslite.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Hermes-Lite control slice testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_hermeslite \
  -f files.f -o sim_hermeslite

./obj_dir/sim_hermeslite 2>&1 | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
